//--- app_fabric.f
design/fabric_pkg.sv
design/bus_decoder.sv
design/sram_core.sv
design/timer_core.sv
design/touch_sense.sv
design/ctrl_core.sv
design/app_fabric.sv
tb/tb_app_fabric.sv

//--- design/app_fabric.sv
// Top level of the bus fabric, joining the master port, decoder, cores and pins
`default_nettype none
`timescale 1ns/1ps

module app_fabric (
  input  logic        clk,
  input  logic        reset_n,
  input  logic        mem_valid,
  input  logic [31:0] mem_addr,
  input  logic [31:0] mem_wdata,
  input  logic [3:0]  mem_wstrb,
  output logic        mem_ready,
  output logic [31:0] mem_rdata,
  input  logic        touch_event,
  input  logic        app_gpio1,
  input  logic        app_gpio2,
  output logic        app_gpio3,
  output logic        app_gpio4,
  output logic        led_r,
  output logic        led_g,
  output logic        led_b
);

  logic        ram_cs;
  logic        timer_cs;
  logic        touch_cs;
  logic        ctrl_cs;
  logic        core_we;
  logic [3:0]  ram_we;
  logic [7:0]  core_address;
  logic [31:0] core_wdata;
  logic        ram_ready;
  logic [31:0] ram_rdata;
  logic [31:0] timer_rdata;
  logic [31:0] touch_rdata;
  logic [31:0] ctrl_rdata;
  logic        fw_app_mode;

  // --------------------------------------------------------------------------
  // Decoder
  // --------------------------------------------------------------------------
  bus_decoder u_decoder (
    .clk          (clk),
    .reset_n      (reset_n),
    .mem_valid    (mem_valid),
    .mem_addr     (mem_addr),
    .mem_wstrb    (mem_wstrb),
    .mem_wdata    (mem_wdata),
    .mem_ready    (mem_ready),
    .mem_rdata    (mem_rdata),
    .ram_ready    (ram_ready),
    .ram_rdata    (ram_rdata),
    .timer_rdata  (timer_rdata),
    .touch_rdata  (touch_rdata),
    .ctrl_rdata   (ctrl_rdata),
    .ram_cs       (ram_cs),
    .timer_cs     (timer_cs),
    .touch_cs     (touch_cs),
    .ctrl_cs      (ctrl_cs),
    .core_we      (core_we),
    .ram_we       (ram_we),
    .core_address (core_address),
    .core_wdata   (core_wdata)
  );

  // --------------------------------------------------------------------------
  // Cores
  // --------------------------------------------------------------------------
  sram_core u_ram (
    .clk         (clk),
    .reset_n     (reset_n),
    .fw_app_mode (fw_app_mode),
    .cs          (ram_cs),
    .we          (ram_we),
    .address     (core_address),
    .write_data  (core_wdata),
    .read_data   (ram_rdata),
    .ready       (ram_ready)
  );

  timer_core u_timer (
    .clk        (clk),
    .reset_n    (reset_n),
    .cs         (timer_cs),
    .we         (core_we),
    .address    (core_address),
    .write_data (core_wdata),
    .read_data  (timer_rdata)
  );

  touch_sense u_touch (
    .clk         (clk),
    .reset_n     (reset_n),
    .touch_event (touch_event),
    .cs          (touch_cs),
    .we          (core_we),
    .address     (core_address),
    .read_data   (touch_rdata)
  );

  ctrl_core u_ctrl (
    .clk         (clk),
    .reset_n     (reset_n),
    .cs          (ctrl_cs),
    .we          (core_we),
    .address     (core_address),
    .write_data  (core_wdata),
    .gpio1       (app_gpio1),
    .gpio2       (app_gpio2),
    .read_data   (ctrl_rdata),
    .fw_app_mode (fw_app_mode),
    .led_r       (led_r),
    .led_g       (led_g),
    .led_b       (led_b),
    .gpio3       (app_gpio3),
    .gpio4       (app_gpio4)
  );

endmodule

`default_nettype wire

//--- design/bus_decoder.sv
// Address decoder: turns master requests into core selects and registers the read-back
`default_nettype none
`timescale 1ns/1ps

module bus_decoder (
  input  logic        clk,
  input  logic        reset_n,

  // Master side
  input  logic        mem_valid,
  input  logic [31:0] mem_addr,
  input  logic [3:0]  mem_wstrb,
  input  logic [31:0] mem_wdata,
  output logic        mem_ready,
  output logic [31:0] mem_rdata,

  // Core side
  input  logic        ram_ready,
  input  logic [31:0] ram_rdata,
  input  logic [31:0] timer_rdata,
  input  logic [31:0] touch_rdata,
  input  logic [31:0] ctrl_rdata,
  output logic        ram_cs,
  output logic        timer_cs,
  output logic        touch_cs,
  output logic        ctrl_cs,
  output logic        core_we,
  output logic [3:0]  ram_we,
  output logic [7:0]  core_address,
  output logic [31:0] core_wdata
);

  fabric_pkg::cpu_addr_t addr;

  logic [31:0] rdata_new;
  logic        ready_new;

  assign addr = mem_addr;

  // Shared request fields, every core sees the same word offset
  assign core_we      = |mem_wstrb;
  assign ram_we       = mem_wstrb;
  assign core_address = addr.mmio_view.offset;
  assign core_wdata   = mem_wdata;

  // --------------------------------------------------------------------------
  // Select and response mux
  // --------------------------------------------------------------------------
  always_comb begin
    ram_cs    = 1'b0;
    timer_cs  = 1'b0;
    touch_cs  = 1'b0;
    ctrl_cs   = 1'b0;
    rdata_new = 32'h0;
    ready_new = 1'b0;

    // Registered ready closes the access, so no select in that cycle
    if (mem_valid && !mem_ready) begin
      case (addr.area_view.area)
        fabric_pkg::area_ram: begin
          ram_cs    = 1'b1;
          rdata_new = ram_rdata;
          ready_new = ram_ready;
        end

        fabric_pkg::area_mmio: begin
          case (addr.mmio_view.core)
            fabric_pkg::core_timer: begin
              timer_cs  = 1'b1;
              rdata_new = timer_rdata;
              ready_new = 1'b1;
            end

            fabric_pkg::core_touch: begin
              touch_cs  = 1'b1;
              rdata_new = touch_rdata;
              ready_new = 1'b1;
            end

            fabric_pkg::core_ctrl: begin
              ctrl_cs   = 1'b1;
              rdata_new = ctrl_rdata;
              ready_new = 1'b1;
            end

            // Unmapped cores answer at once with zero
            default: begin
              rdata_new = 32'h0;
              ready_new = 1'b1;
            end
          endcase
        end

        fabric_pkg::area_rom, fabric_pkg::area_reserved: begin
          rdata_new = 32'h0;
          ready_new = 1'b1;
        end
      endcase
    end
  end

  // --------------------------------------------------------------------------
  // Response register toward the master
  // --------------------------------------------------------------------------
  always_ff @(posedge clk) begin
    if (!reset_n) begin
      mem_ready <= 1'b0;
      mem_rdata <= 32'h0;
    end else begin
      mem_ready <= ready_new;
      mem_rdata <= rdata_new;
    end
  end

endmodule

`default_nettype wire

//--- design/ctrl_core.sv
// Control core with identity, sticky app mode flag, RGB LEDs and GPIO pairs
`default_nettype none
`timescale 1ns/1ps

module ctrl_core (
  input  logic        clk,
  input  logic        reset_n,
  input  logic        cs,
  input  logic        we,
  input  logic [7:0]  address,
  input  logic [31:0] write_data,
  input  logic        gpio1,
  input  logic        gpio2,
  output logic [31:0] read_data,
  output logic        fw_app_mode,
  output logic        led_r,
  output logic        led_g,
  output logic        led_b,
  output logic        gpio3,
  output logic        gpio4
);

  logic [2:0] led_reg;
  logic [1:0] gpio_out;
  logic [1:0] gpio_meta;
  logic [1:0] gpio_sync;

  assign led_r = led_reg[2];
  assign led_g = led_reg[1];
  assign led_b = led_reg[0];
  assign gpio3 = gpio_out[0];
  assign gpio4 = gpio_out[1];

  // --------------------------------------------------------------------------
  // Registers
  // --------------------------------------------------------------------------
  always_ff @(posedge clk) begin
    if (!reset_n) begin
      fw_app_mode <= 1'b0;
      led_reg     <= 3'h0;
      gpio_out    <= 2'h0;
      gpio_meta   <= 2'h0;
      gpio_sync   <= 2'h0;
    end else begin
      gpio_meta <= {gpio2, gpio1};
      gpio_sync <= gpio_meta;

      if (cs && we) begin
        case (address)
          // Once set, only reset brings the core back to firmware mode
          fabric_pkg::ctrl_addr_app_mode: fw_app_mode <= 1'b1;
          fabric_pkg::ctrl_addr_led:      led_reg <= write_data[2:0];
          fabric_pkg::ctrl_addr_gpio:     gpio_out <= write_data[3:2];
          default: ;
        endcase
      end
    end
  end

  // Read mux
  always_comb begin
    case (address)
      fabric_pkg::ctrl_addr_name:     read_data = fabric_pkg::ctrl_name_value;
      fabric_pkg::ctrl_addr_app_mode: read_data = {31'h0, fw_app_mode};
      fabric_pkg::ctrl_addr_led:      read_data = {29'h0, led_reg};
      fabric_pkg::ctrl_addr_gpio:     read_data = {28'h0, gpio_out, gpio_sync};
      default:                        read_data = 32'h0;
    endcase
  end

endmodule

`default_nettype wire

//--- design/fabric_pkg.sv
// Shared memory map, register offsets and address views for the bus fabric, used by scoped names
`default_nettype none

package fabric_pkg;

  // --------------------------------------------------------------------------
  // Top level areas, selected by address bits 31:30
  // --------------------------------------------------------------------------
  localparam logic [1:0] area_rom      = 2'h0;
  localparam logic [1:0] area_ram      = 2'h1;
  localparam logic [1:0] area_reserved = 2'h2;
  localparam logic [1:0] area_mmio     = 2'h3;

  // MMIO core prefixes, address bits 29:24
  localparam logic [5:0] core_timer = 6'h01;
  localparam logic [5:0] core_touch = 6'h04;
  localparam logic [5:0] core_ctrl  = 6'h3f;

  // Timer registers
  localparam logic [7:0] timer_addr_ctrl      = 8'h08;
  localparam logic [7:0] timer_addr_status    = 8'h09;
  localparam logic [7:0] timer_addr_prescaler = 8'h0a;
  localparam logic [7:0] timer_addr_value     = 8'h0b;

  // Touch sense registers
  localparam logic [7:0] touch_addr_status = 8'h09;

  // Control core registers
  localparam logic [7:0] ctrl_addr_name     = 8'h00;
  localparam logic [7:0] ctrl_addr_app_mode = 8'h08;
  localparam logic [7:0] ctrl_addr_led      = 8'h09;
  localparam logic [7:0] ctrl_addr_gpio     = 8'h0a;

  // Reads back as "app1"
  localparam logic [31:0] ctrl_name_value = 32'h6170_7031;

  // First word of the firmware-only RAM quarter
  localparam logic [7:0] ram_fw_base = 8'hc0;

  // One master address, seen either as an area or as an MMIO register
  typedef union packed {
    struct packed {
      logic [1:0]  area;
      logic [29:0] rest;
    } area_view;
    struct packed {
      logic [1:0]  area;
      logic [5:0]  core;
      logic [13:0] unused;
      logic [7:0]  offset;
      logic [1:0]  byte_sel;
    } mmio_view;
  } cpu_addr_t;

endpackage

`default_nettype wire

//--- design/sram_core.sv
// Byte-writable 256-word RAM with registered read and an upper quarter locked in app mode
`default_nettype none
`timescale 1ns/1ps

module sram_core (
  input  logic        clk,
  input  logic        reset_n,
  input  logic        fw_app_mode,
  input  logic        cs,
  input  logic [3:0]  we,
  input  logic [7:0]  address,
  input  logic [31:0] write_data,
  output logic [31:0] read_data,
  output logic        ready
);

  logic [31:0] mem [0:255];
  logic        fw_blocked;

  // Firmware area is hidden from applications
  assign fw_blocked = fw_app_mode && (address >= fabric_pkg::ram_fw_base);

  always_ff @(posedge clk) begin
    if (cs && !fw_blocked) begin
      for (int i = 0; i < 4; i++) begin
        if (we[i]) begin
          mem[address][8*i +: 8] <= write_data[8*i +: 8];
        end
      end
    end
    if (cs) begin
      read_data <= fw_blocked ? 32'h0 : mem[address];
    end
  end

  // Data is ready one cycle after the select
  always_ff @(posedge clk) begin
    if (!reset_n) begin
      ready <= 1'b0;
    end else begin
      ready <= cs;
    end
  end

endmodule

`default_nettype wire

//--- design/timer_core.sv
// Down-counting timer with prescaler, started and stopped through its control register
`default_nettype none
`timescale 1ns/1ps

module timer_core (
  input  logic        clk,
  input  logic        reset_n,
  input  logic        cs,
  input  logic        we,
  input  logic [7:0]  address,
  input  logic [31:0] write_data,
  output logic [31:0] read_data
);

  logic [31:0] prescaler;
  logic [31:0] load_value;
  logic [31:0] count;
  logic [31:0] prescale_cnt;
  logic        running;

  // --------------------------------------------------------------------------
  // Count and register writes
  // --------------------------------------------------------------------------
  always_ff @(posedge clk) begin
    if (!reset_n) begin
      prescaler    <= 32'h0;
      load_value   <= 32'h0;
      count        <= 32'h0;
      prescale_cnt <= 32'h0;
      running      <= 1'b0;
    end else begin
      if (running) begin
        if (count == 32'h0) begin
          running <= 1'b0;
        end else if (prescale_cnt == prescaler) begin
          prescale_cnt <= 32'h0;
          count        <= count - 32'h1;
          // Stop on the step that reaches zero
          if (count == 32'h1) begin
            running <= 1'b0;
          end
        end else begin
          prescale_cnt <= prescale_cnt + 32'h1;
        end
      end

      // Software writes win over the count step
      if (cs && we) begin
        case (address)
          fabric_pkg::timer_addr_ctrl: begin
            if (write_data[0]) begin
              count        <= load_value;
              prescale_cnt <= 32'h0;
              running      <= 1'b1;
            end
            if (write_data[1]) begin
              running <= 1'b0;
            end
          end
          fabric_pkg::timer_addr_prescaler: prescaler <= write_data;
          fabric_pkg::timer_addr_value:     load_value <= write_data;
          default: ;
        endcase
      end
    end
  end

  // Read mux
  always_comb begin
    case (address)
      fabric_pkg::timer_addr_status:    read_data = {31'h0, running};
      fabric_pkg::timer_addr_prescaler: read_data = prescaler;
      fabric_pkg::timer_addr_value:     read_data = count;
      default:                          read_data = 32'h0;
    endcase
  end

endmodule

`default_nettype wire

//--- design/touch_sense.sv
// Touch input synchronizer that latches a rising edge until software clears the status
`default_nettype none
`timescale 1ns/1ps

module touch_sense (
  input  logic        clk,
  input  logic        reset_n,
  input  logic        touch_event,
  input  logic        cs,
  input  logic        we,
  input  logic [7:0]  address,
  output logic [31:0] read_data
);

  logic touch_meta;
  logic touch_sync;
  logic touch_prev;
  logic touch_rise;
  logic event_flag;

  assign touch_rise = touch_sync && !touch_prev;

  // --------------------------------------------------------------------------
  // Synchronizer and sticky event
  // --------------------------------------------------------------------------
  always_ff @(posedge clk) begin
    if (!reset_n) begin
      touch_meta <= 1'b0;
      touch_sync <= 1'b0;
      touch_prev <= 1'b0;
      event_flag <= 1'b0;
    end else begin
      touch_meta <= touch_event;
      touch_sync <= touch_meta;
      touch_prev <= touch_sync;

      // A fresh edge beats a clear in the same cycle
      if (touch_rise) begin
        event_flag <= 1'b1;
      end else if (cs && we && (address == fabric_pkg::touch_addr_status)) begin
        event_flag <= 1'b0;
      end
    end
  end

  always_comb begin
    if (address == fabric_pkg::touch_addr_status) begin
      read_data = {31'h0, event_flag};
    end else begin
      read_data = 32'h0;
    end
  end

endmodule

`default_nettype wire

//--- tb/tb_app_fabric.sv
// Testbench that acts as bus master on the fabric top level and checks each core by assertions
`default_nettype none
`timescale 1ns/1ps

module tb_app_fabric;

  localparam int timeout_cycles = 3000;

  logic        clk;
  logic        reset_n;
  logic        mem_valid;
  logic [31:0] mem_addr;
  logic [31:0] mem_wdata;
  logic [3:0]  mem_wstrb;
  logic        mem_ready;
  logic [31:0] mem_rdata;
  logic        touch_event;
  logic        app_gpio1;
  logic        app_gpio2;
  logic        app_gpio3;
  logic        app_gpio4;
  logic        led_r;
  logic        led_g;
  logic        led_b;

  int          error_count;
  int          cycle_count;
  int          last_latency;
  logic        prev_ready;
  logic        prev_valid;

  // Expected RAM contents tracked by byte merging
  logic [31:0] ram_model [0:255];
  logic [7:0]  ram_offs  [0:7];

  app_fabric dut (
    .clk         (clk),
    .reset_n     (reset_n),
    .mem_valid   (mem_valid),
    .mem_addr    (mem_addr),
    .mem_wdata   (mem_wdata),
    .mem_wstrb   (mem_wstrb),
    .mem_ready   (mem_ready),
    .mem_rdata   (mem_rdata),
    .touch_event (touch_event),
    .app_gpio1   (app_gpio1),
    .app_gpio2   (app_gpio2),
    .app_gpio3   (app_gpio3),
    .app_gpio4   (app_gpio4),
    .led_r       (led_r),
    .led_g       (led_g),
    .led_b       (led_b)
  );

  always #20 clk = ~clk;

  // --------------------------------------------------------------------------
  // Helpers
  // --------------------------------------------------------------------------
  function automatic logic [31:0] ram_addr(input logic [7:0] offset);
    ram_addr = {fabric_pkg::area_ram, 20'h0, offset, 2'b00};
  endfunction

  function automatic logic [31:0] mmio_addr(input logic [5:0] core, input logic [7:0] offset);
    mmio_addr = {fabric_pkg::area_mmio, core, 14'h0, offset, 2'b00};
  endfunction

  function automatic logic [31:0] merge_bytes(input logic [31:0] old_word,
                                              input logic [31:0] new_word,
                                              input logic [3:0]  strb);
    logic [31:0] mask;
    mask = {{8{strb[3]}}, {8{strb[2]}}, {8{strb[1]}}, {8{strb[0]}}};
    merge_bytes = (old_word & ~mask) | (new_word & mask);
  endfunction

  task automatic check_word(input string name, input logic [31:0] expected,
                            input logic [31:0] actual);
    assert (actual === expected) else begin
      error_count++;
      $display("[FAIL] %s: expected %h, actual %h", name, expected, actual);
    end
  endtask

  task automatic check_at_most(input string name, input logic [31:0] limit,
                               input logic [31:0] actual);
    assert (actual <= limit) else begin
      error_count++;
      $display("[FAIL] %s: expected at most %0d, actual %0d", name, limit, actual);
    end
  endtask

  // One access with the request set up on a falling edge and held until ready
  task automatic bus_access(input logic [31:0] addr, input logic [31:0] wdata,
                            input logic [3:0] strb, output logic [31:0] rdata);
    @(negedge clk);
    mem_valid    = 1'b1;
    mem_addr     = addr;
    mem_wdata    = wdata;
    mem_wstrb    = strb;
    last_latency = 0;
    do begin
      @(negedge clk);
      last_latency++;
    end while (!mem_ready);
    rdata     = mem_rdata;
    mem_valid = 1'b0;
    mem_wstrb = 4'h0;
  endtask

  task automatic bus_write(input logic [31:0] addr, input logic [31:0] data,
                           input logic [3:0] strb);
    logic [31:0] unused_data;
    bus_access(addr, data, strb, unused_data);
  endtask

  task automatic bus_read(input logic [31:0] addr, output logic [31:0] data);
    bus_access(addr, 32'h0, 4'h0, data);
  endtask

  // --------------------------------------------------------------------------
  // Protocol monitor and timeout
  // --------------------------------------------------------------------------
  always @(posedge clk) begin
    cycle_count <= cycle_count + 1;
    if (cycle_count >= timeout_cycles) begin
      $display("Timeout: the run did not finish within %0d cycles", timeout_cycles);
      $display("Done: errors found");
      $finish;
    end
  end

  always @(posedge clk) begin
    if (!reset_n) begin
      prev_ready <= 1'b0;
      prev_valid <= 1'b0;
    end else begin
      assert (!(mem_ready && prev_ready)) else begin
        error_count++;
        $display("[FAIL] protocol: mem_ready stayed high for two cycles in a row");
      end
      assert (!(mem_ready && !prev_ready && !prev_valid)) else begin
        error_count++;
        $display("[FAIL] protocol: mem_ready rose without a request in the cycle before");
      end
      prev_ready <= mem_ready;
      prev_valid <= mem_valid;
    end
  end

  // --------------------------------------------------------------------------
  // Stimulus
  // --------------------------------------------------------------------------
  initial begin
    logic [31:0] rd;
    logic [31:0] wd;
    logic [31:0] prev_value;
    logic [31:0] value_a;
    logic [3:0]  strb;
    logic [2:0]  led_val;
    logic [1:0]  gpio_val;
    int          start_cycle;
    int          seed_dummy;

    seed_dummy  = $urandom(32'h5640_afdf);
    clk         = 1'b0;
    reset_n     = 1'b0;
    mem_valid   = 1'b0;
    mem_addr    = 32'h0;
    mem_wdata   = 32'h0;
    mem_wstrb   = 4'h0;
    touch_event = 1'b0;
    app_gpio1   = 1'b0;
    app_gpio2   = 1'b0;
    error_count = 0;
    cycle_count = 0;
    repeat (4) @(negedge clk);
    reset_n = 1'b1;

    // RAM words then single bytes at distinct offsets below the firmware area
    for (int i = 0; i < 8; i++) begin
      ram_offs[i] = 8'(i * 16 + ($urandom % 16));
      wd = $urandom;
      bus_write(ram_addr(ram_offs[i]), wd, 4'hf);
      ram_model[ram_offs[i]] = wd;
      check_word("ram write latency", 2, last_latency);
    end
    for (int i = 0; i < 8; i++) begin
      strb = 4'b0001 << (i % 4);
      wd   = $urandom;
      bus_write(ram_addr(ram_offs[i]), wd, strb);
      ram_model[ram_offs[i]] = merge_bytes(ram_model[ram_offs[i]], wd, strb);
    end
    for (int i = 0; i < 8; i++) begin
      bus_read(ram_addr(ram_offs[i]), rd);
      check_word("ram read back", ram_model[ram_offs[i]], rd);
      check_word("ram read latency", 2, last_latency);
    end

    // Unmapped and reserved targets
    bus_read({fabric_pkg::area_rom, 20'h0, ram_offs[0], 2'b00}, rd);
    check_word("rom area read", 0, rd);
    check_word("rom area latency", 1, last_latency);
    bus_read({fabric_pkg::area_reserved, 20'h0, ram_offs[0], 2'b00}, rd);
    check_word("reserved area read", 0, rd);
    check_word("reserved area latency", 1, last_latency);
    for (int c = 0; c < 4; c++) begin
      if (c != 1) begin
        bus_read(mmio_addr(6'(c), ram_offs[0]), rd);
        check_word("unmapped core read", 0, rd);
        check_word("unmapped core latency", 1, last_latency);
      end
    end
    bus_write({fabric_pkg::area_rom, 20'h0, ram_offs[0], 2'b00}, 32'hdead_beef, 4'hf);
    bus_write({fabric_pkg::area_reserved, 20'h0, ram_offs[0], 2'b00}, 32'hdead_beef, 4'hf);
    bus_write(mmio_addr(6'h00, ram_offs[0]), 32'hdead_beef, 4'hf);
    bus_read(ram_addr(ram_offs[0]), rd);
    check_word("ram after unmapped writes", ram_model[ram_offs[0]], rd);

    // Timer runs 20 steps of 2 cycles each
    bus_write(mmio_addr(fabric_pkg::core_timer, fabric_pkg::timer_addr_value), 20, 4'hf);
    bus_write(mmio_addr(fabric_pkg::core_timer, fabric_pkg::timer_addr_prescaler), 1, 4'hf);
    bus_write(mmio_addr(fabric_pkg::core_timer, fabric_pkg::timer_addr_ctrl), 1, 4'hf);
    start_cycle = cycle_count;
    bus_read(mmio_addr(fabric_pkg::core_timer, fabric_pkg::timer_addr_status), rd);
    check_word("timer running after start", 1, rd);
    prev_value = 20;
    for (int n = 0; n < 30 && rd[0]; n++) begin
      bus_read(mmio_addr(fabric_pkg::core_timer, fabric_pkg::timer_addr_value), value_a);
      check_at_most("timer value decreasing", prev_value, value_a);
      prev_value = value_a;
      bus_read(mmio_addr(fabric_pkg::core_timer, fabric_pkg::timer_addr_status), rd);
    end
    check_word("timer stopped at zero", 0, rd);
    check_at_most("timer run length", 45, cycle_count - start_cycle);
    bus_read(mmio_addr(fabric_pkg::core_timer, fabric_pkg::timer_addr_value), rd);
    check_word("timer final value", 0, rd);

    bus_write(mmio_addr(fabric_pkg::core_timer, fabric_pkg::timer_addr_ctrl), 1, 4'hf);
    bus_write(mmio_addr(fabric_pkg::core_timer, fabric_pkg::timer_addr_ctrl), 2, 4'hf);
    bus_read(mmio_addr(fabric_pkg::core_timer, fabric_pkg::timer_addr_status), rd);
    check_word("timer status after stop", 0, rd);
    bus_read(mmio_addr(fabric_pkg::core_timer, fabric_pkg::timer_addr_value), value_a);
    repeat (4) @(negedge clk);
    bus_read(mmio_addr(fabric_pkg::core_timer, fabric_pkg::timer_addr_value), rd);
    check_word("timer value frozen", value_a, rd);

    // Touch sense
    bus_read(mmio_addr(fabric_pkg::core_touch, fabric_pkg::touch_addr_status), rd);
    check_word("touch idle status", 0, rd);
    @(negedge clk);
    touch_event = 1'b1;
    repeat (2) @(negedge clk);
    touch_event = 1'b0;
    repeat (2) @(negedge clk);
    bus_read(mmio_addr(fabric_pkg::core_touch, fabric_pkg::touch_addr_status), rd);
    check_word("touch event latched", 1, rd);
    repeat (3) @(negedge clk);
    bus_read(mmio_addr(fabric_pkg::core_touch, fabric_pkg::touch_addr_status), rd);
    check_word("touch event held", 1, rd);
    bus_write(mmio_addr(fabric_pkg::core_touch, fabric_pkg::touch_addr_status), 0, 4'hf);
    bus_read(mmio_addr(fabric_pkg::core_touch, fabric_pkg::touch_addr_status), rd);
    check_word("touch event cleared", 0, rd);

    // Control core
    bus_read(mmio_addr(fabric_pkg::core_ctrl, fabric_pkg::ctrl_addr_name), rd);
    check_word("ctrl name", fabric_pkg::ctrl_name_value, rd);
    led_val = 3'($urandom);
    bus_write(mmio_addr(fabric_pkg::core_ctrl, fabric_pkg::ctrl_addr_led), led_val, 4'hf);
    check_word("led pins", led_val, {led_r, led_g, led_b});
    gpio_val = 2'($urandom);
    bus_write(mmio_addr(fabric_pkg::core_ctrl, fabric_pkg::ctrl_addr_gpio),
              {28'h0, gpio_val, 2'b00}, 4'hf);
    check_word("gpio output pins", gpio_val, {app_gpio4, app_gpio3});
    app_gpio1 = 1'($urandom);
    app_gpio2 = 1'($urandom);
    repeat (3) @(negedge clk);
    bus_read(mmio_addr(fabric_pkg::core_ctrl, fabric_pkg::ctrl_addr_gpio), rd);
    check_word("gpio read back", {28'h0, gpio_val, app_gpio2, app_gpio1}, rd);

    // Application mode locks the upper RAM quarter
    wd = $urandom;
    bus_write(ram_addr(8'hc4), wd, 4'hf);
    bus_read(ram_addr(8'hc4), rd);
    check_word("fw word before app mode", wd, rd);
    bus_write(mmio_addr(fabric_pkg::core_ctrl, fabric_pkg::ctrl_addr_app_mode), 1, 4'hf);
    bus_read(mmio_addr(fabric_pkg::core_ctrl, fabric_pkg::ctrl_addr_app_mode), rd);
    check_word("app mode set", 1, rd);
    bus_read(ram_addr(8'hc4), rd);
    check_word("fw word hidden", 0, rd);
    bus_write(ram_addr(8'hc4), ~wd, 4'hf);
    bus_read(ram_addr(8'hc4), rd);
    check_word("fw word write ignored", 0, rd);
    wd = $urandom;
    bus_write(ram_addr(8'h40), wd, 4'hf);
    bus_read(ram_addr(8'h40), rd);
    check_word("app word in app mode", wd, rd);
    bus_write(mmio_addr(fabric_pkg::core_ctrl, fabric_pkg::ctrl_addr_app_mode), 0, 4'hf);
    bus_read(mmio_addr(fabric_pkg::core_ctrl, fabric_pkg::ctrl_addr_app_mode), rd);
    check_word("app mode sticky", 1, rd);

    repeat (2) @(negedge clk);
    $display("Errors: %0d", error_count);
    if (error_count == 0) begin
      $display("Done: no errors");
    end else begin
      $display("Done: errors found");
    end
    $finish;
  end

endmodule

`default_nettype wire
